// File: common/ep_pkg.sv
package ep_pkg;

	////////////////////
	// endpoint map
	////////////////////

	typedef logic [7:0] ep_addr_t;

	// wire-ins
	localparam ep_addr_t ADC_OS_WEP            = 8'h00;
	localparam ep_addr_t OSF_ACTIVATE_WEP      = 8'h01;
	localparam ep_addr_t OSF_CYCLE_DELAY_WEP   = 8'h02;
	localparam ep_addr_t OSF_OSM_WEP           = 8'h03;
	localparam ep_addr_t OSF_UPDATE_EN_WEP     = 8'h04;
	localparam ep_addr_t PID_LOCK_EN_WEP       = 8'h05;
	localparam ep_addr_t PID_SETPOINT_WEP      = 8'h06;
	localparam ep_addr_t PID_P_COEF_WEP        = 8'h07;
	localparam ep_addr_t PID_I_COEF_WEP        = 8'h08;
	localparam ep_addr_t PID_D_COEF_WEP        = 8'h09;
	localparam ep_addr_t PID_UPDATE_EN_WEP     = 8'h0A;
	localparam ep_addr_t RTR_SRC_SEL_WEP       = 8'h0B;
	localparam ep_addr_t RTR_DEST_SEL_WEP      = 8'h0C;
	localparam ep_addr_t RTR_OUTPUT_ACTIVE_WEP = 8'h0D;
	localparam ep_addr_t OPP_MIN0_WEP          = 8'h0E;
	localparam ep_addr_t OPP_MIN1_WEP          = 8'h0F;
	localparam ep_addr_t OPP_MIN2_WEP          = 8'h10;
	localparam ep_addr_t OPP_MAX0_WEP          = 8'h11;
	localparam ep_addr_t OPP_MAX1_WEP          = 8'h12;
	localparam ep_addr_t OPP_MAX2_WEP          = 8'h13;
	localparam ep_addr_t OPP_INIT0_WEP         = 8'h14;
	localparam ep_addr_t OPP_INIT1_WEP         = 8'h15;
	localparam ep_addr_t OPP_INIT2_WEP         = 8'h16;
	localparam ep_addr_t OPP_UPDATE_EN_WEP     = 8'h17;

	localparam int N_WIRE_IN = 24;	// wire-ins live at 0x00 .. N_WIRE_IN-1

	localparam ep_addr_t ADC_DATA0_OWEP = 8'h20;	// channel n at 0x20 + n

	// triggers
	localparam ep_addr_t ADC_CSTART_TEP    = 8'h40;
	localparam ep_addr_t PID_CLEAR_TEP     = 8'h41;
	localparam ep_addr_t DAC_REF_SET_TEP   = 8'h42;
	localparam ep_addr_t MODULE_UPDATE_TEP = 8'h43;
	localparam ep_addr_t SYS_RESET_TEP     = 8'h44;

	localparam ep_addr_t OSF_PIPE_PEP = 8'hA0;	// channel 0 sample pipe

	////////////////////
	// host bus
	////////////////////

	typedef struct packed {
		logic		strobe;	// one cycle per command
		logic		write;	// 0 = read
		ep_addr_t	addr;
		logic [15:0]	data;
	} host_cmd_t;

	typedef struct packed {
		logic		valid;
		logic		unmapped;	// nobody owns the address
		logic		pipe_empty;	// pipe read hit an empty fifo
		logic [15:0]	data;
	} host_reply_t;

	localparam logic [15:0] UNMAPPED_WORD = 16'hDEAD;

endpackage

// File: common/cfg_pkg.sv
package cfg_pkg;

	// raw 16 bit words as the host writes them, sliced at the top level

	////////////////////
	// wire-in groups
	////////////////////

	typedef struct packed {
		logic [15:0]	activate;	// per channel enable
		logic [15:0]	cycle_delay;
		logic [15:0]	osm;	// oversample ratio, log2
		logic [15:0]	update_en;
	} osf_cfg_t;

	typedef struct packed {
		logic [15:0]	lock_en;
		logic [15:0]	setpoint;
		logic [15:0]	p_coef;
		logic [15:0]	i_coef;
		logic [15:0]	d_coef;
		logic [15:0]	update_en;
	} pid_cfg_t;

	typedef struct packed {
		logic [15:0]	src_sel;
		logic [15:0]	dest_sel;
		logic [15:0]	output_active;
	} rtr_cfg_t;

	// 48 bit limits, word 0 in the low bits
	typedef struct packed {
		logic [47:0]	min;
		logic [47:0]	max;
		logic [47:0]	init;
		logic [15:0]	update_en;
	} opp_cfg_t;

	////////////////////
	// trigger masks
	////////////////////

	typedef struct packed {
		logic [15:0]	adc_cstart;
		logic [15:0]	pid_clear;
		logic [15:0]	dac_ref_set;
		logic [15:0]	module_update;
		logic [15:0]	sys_reset;
	} trig_t;

endpackage

// File: logic/config_regs.sv
`timescale 1ns/10ps

module config_regs (
	input	logic			clk50_in,
	input	logic			arst_n,
	input	ep_pkg::host_cmd_t	host_cmd,

	output	cfg_pkg::osf_cfg_t	osf_cfg,
	output	cfg_pkg::pid_cfg_t	pid_cfg,
	output	cfg_pkg::rtr_cfg_t	rtr_cfg,
	output	cfg_pkg::opp_cfg_t	opp_cfg,
	output	logic [15:0]		adc_os_word,
	output	cfg_pkg::trig_t		trig,	// one cycle pulse masks
	output	ep_pkg::host_reply_t	cfg_reply
);

	import ep_pkg::*;
	import cfg_pkg::*;

	localparam int W_IDX = $clog2(N_WIRE_IN);

	////////////////////
	// decode
	////////////////////

	logic			wr_en;
	logic			rd_en;
	logic			is_wire_in;
	logic [W_IDX-1:0]	wi_idx;

	assign wr_en      = host_cmd.strobe & host_cmd.write;
	assign rd_en      = host_cmd.strobe & ~host_cmd.write;
	assign is_wire_in = (host_cmd.addr < N_WIRE_IN);	// 0x00 .. 0x17
	assign wi_idx     = host_cmd.addr[W_IDX-1:0];

	////////////////////
	// wire-in bank
	////////////////////

	logic [N_WIRE_IN-1:0][15:0] wire_in;	// indexed by endpoint address

	always_ff @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			wire_in <= '0;
		end else if (wr_en && is_wire_in) begin
			wire_in[wi_idx] <= host_cmd.data;
		end
	end

	// group the words for the downstream blocks
	assign adc_os_word = wire_in[ADC_OS_WEP];

	assign osf_cfg.activate    = wire_in[OSF_ACTIVATE_WEP];
	assign osf_cfg.cycle_delay = wire_in[OSF_CYCLE_DELAY_WEP];
	assign osf_cfg.osm         = wire_in[OSF_OSM_WEP];
	assign osf_cfg.update_en   = wire_in[OSF_UPDATE_EN_WEP];

	assign pid_cfg.lock_en   = wire_in[PID_LOCK_EN_WEP];
	assign pid_cfg.setpoint  = wire_in[PID_SETPOINT_WEP];
	assign pid_cfg.p_coef    = wire_in[PID_P_COEF_WEP];
	assign pid_cfg.i_coef    = wire_in[PID_I_COEF_WEP];
	assign pid_cfg.d_coef    = wire_in[PID_D_COEF_WEP];
	assign pid_cfg.update_en = wire_in[PID_UPDATE_EN_WEP];

	assign rtr_cfg.src_sel       = wire_in[RTR_SRC_SEL_WEP];
	assign rtr_cfg.dest_sel      = wire_in[RTR_DEST_SEL_WEP];
	assign rtr_cfg.output_active = wire_in[RTR_OUTPUT_ACTIVE_WEP];

	// three words per limit, word 0 lowest
	assign opp_cfg.min  = {wire_in[OPP_MIN2_WEP], wire_in[OPP_MIN1_WEP], wire_in[OPP_MIN0_WEP]};
	assign opp_cfg.max  = {wire_in[OPP_MAX2_WEP], wire_in[OPP_MAX1_WEP], wire_in[OPP_MAX0_WEP]};
	assign opp_cfg.init = {wire_in[OPP_INIT2_WEP], wire_in[OPP_INIT1_WEP],
		wire_in[OPP_INIT0_WEP]};
	assign opp_cfg.update_en = wire_in[OPP_UPDATE_EN_WEP];

	////////////////////
	// triggers
	////////////////////

	always_ff @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			trig <= '0;
		end else begin
			trig <= '0;	// pulses clear on their own
			if (wr_en) begin
				case (host_cmd.addr)
					ADC_CSTART_TEP:    trig.adc_cstart    <= host_cmd.data;
					PID_CLEAR_TEP:     trig.pid_clear     <= host_cmd.data;
					DAC_REF_SET_TEP:   trig.dac_ref_set   <= host_cmd.data;
					MODULE_UPDATE_TEP: trig.module_update <= host_cmd.data;
					SYS_RESET_TEP:     trig.sys_reset     <= host_cmd.data;
					default: ;	// not a trigger
				endcase
			end
		end
	end

	////////////////////
	// readback
	////////////////////

	// triggers are write only, so reads of them stay unclaimed
	always_ff @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			cfg_reply <= '0;
		end else begin
			cfg_reply <= '0;
			if (rd_en && is_wire_in) begin
				cfg_reply.valid <= 1'b1;
				cfg_reply.data  <= wire_in[wi_idx];	// word as written
			end
		end
	end

endmodule

// File: logic/adc_readback.sv
`timescale 1ns/10ps

module adc_readback #(
	parameter int N_ADC      = 8,	// adc channels
	parameter int W_ADC_DATA = 18,	// sample width
	parameter int FIFO_DEPTH = 16	// power of two
) (
	input	logic				clk50_in,
	input	logic				arst_n,
	input	ep_pkg::host_cmd_t		host_cmd,
	input	logic [N_ADC-1:0]		adc_data_valid,
	input	logic [W_ADC_DATA-1:0]		adc_data_a,	// feeds the low half
	input	logic [W_ADC_DATA-1:0]		adc_data_b,	// feeds the high half
	output	ep_pkg::host_reply_t		adc_reply
);

	import ep_pkg::*;

	localparam int W_CH  = $clog2(N_ADC);
	localparam int W_PTR = $clog2(FIFO_DEPTH);

	////////////////////
	// decode
	////////////////////

	logic			rd_en;
	logic			is_wire_out;
	logic			is_pipe;
	logic [7:0]		ow_offset;
	logic [W_CH-1:0]	ow_idx;

	assign rd_en       = host_cmd.strobe & ~host_cmd.write;
	assign is_wire_out = (host_cmd.addr >= ADC_DATA0_OWEP) &&
		(host_cmd.addr < ADC_DATA0_OWEP + N_ADC);
	assign is_pipe     = (host_cmd.addr == OSF_PIPE_PEP);
	assign ow_offset   = host_cmd.addr - ADC_DATA0_OWEP;
	assign ow_idx      = ow_offset[W_CH-1:0];	// channel number

	////////////////////
	// hold slots
	////////////////////

	logic [N_ADC-1:0][W_ADC_DATA-1:0] slot;

	// a and b share a pair of valids, a wins when both fire
	always_ff @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			slot <= '0;
		end else begin
			for (int i = 0; i < N_ADC/2; i++) begin
				if (adc_data_valid[i]) begin
					slot[i] <= adc_data_a;
				end else if (adc_data_valid[i + N_ADC/2]) begin
					slot[i + N_ADC/2] <= adc_data_b;
				end
			end
		end
	end

	////////////////////
	// channel 0 fifo
	////////////////////

	logic [15:0]		fifo_mem [FIFO_DEPTH];
	logic [W_PTR:0]		wr_ptr;	// extra bit tells full from empty
	logic [W_PTR:0]		rd_ptr;
	logic			full;
	logic			empty;
	logic			push;
	logic			pop;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[W_PTR] != rd_ptr[W_PTR]) &&
		(wr_ptr[W_PTR-1:0] == rd_ptr[W_PTR-1:0]);
	assign push  = adc_data_valid[0] & ~full;	// drop on full
	assign pop   = rd_en & is_pipe & ~empty;

	always_ff @(posedge clk50_in) begin
		if (push) begin
			fifo_mem[wr_ptr[W_PTR-1:0]] <= adc_data_a[W_ADC_DATA-1 -: 16];	// upper bits
		end
	end

	always_ff @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	////////////////////
	// read replies
	////////////////////

	always_ff @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			adc_reply <= '0;
		end else begin
			adc_reply <= '0;
			if (rd_en && is_wire_out) begin
				adc_reply.valid <= 1'b1;
				adc_reply.data  <= slot[ow_idx][W_ADC_DATA-1 -: 16];
			end else if (rd_en && is_pipe) begin
				adc_reply.valid      <= 1'b1;
				adc_reply.pipe_empty <= empty;
				adc_reply.data       <= empty ? 16'h0000 : fifo_mem[rd_ptr[W_PTR-1:0]];
			end
		end
	end

endmodule

// File: logic/reply_merge.sv
`timescale 1ns/10ps

module reply_merge (
	input	logic			clk50_in,
	input	logic			arst_n,
	input	ep_pkg::host_cmd_t	host_cmd,
	input	ep_pkg::host_reply_t	cfg_reply,	// wire-in readback
	input	ep_pkg::host_reply_t	adc_reply,	// wire-out and pipe
	output	ep_pkg::host_reply_t	host_reply
);

	import ep_pkg::*;

	////////////////////
	// read tracking
	////////////////////

	logic rd_q;	// lines up with the block replies

	always_ff @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			rd_q <= 1'b0;
		end else begin
			rd_q <= host_cmd.strobe & ~host_cmd.write;
		end
	end

	////////////////////
	// merge
	////////////////////

	host_reply_t	merged;
	logic		claimed;

	assign claimed = cfg_reply.valid | adc_reply.valid;

	// idle blocks drive zero, so an or is enough
	always_comb begin
		merged            = cfg_reply | adc_reply;
		merged.valid      = rd_q;
		merged.unmapped   = rd_q & ~claimed;
		if (rd_q && !claimed)
			merged.data = UNMAPPED_WORD;
	end

	always_ff @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			host_reply <= '0;
		end else begin
			host_reply <= merged;	// second stage, read latency 2
		end
	end

endmodule

// File: frontpanel_interface/frontpanel_interface.sv
`timescale 1ns/10ps

module frontpanel_interface #(
	parameter int N_ADC      = 8,	// adc channels
	parameter int W_ADC_DATA = 18,	// adc sample width
	parameter int N_OUT      = 8,	// output channels
	parameter int FIFO_DEPTH = 16	// pipe fifo words
) (
	input	logic			clk50_in,
	input	logic			arst_n,

	// host bus
	input	ep_pkg::host_cmd_t	host_cmd,
	output	ep_pkg::host_reply_t	host_reply,

	// adc controller
	input	logic [N_ADC-1:0]	adc_data_valid,
	input	logic [W_ADC_DATA-1:0]	adc_data_a,
	input	logic [W_ADC_DATA-1:0]	adc_data_b,
	output	logic [2:0]		adc_os,
	output	logic			adc_cstart,

	// oversample filter
	output	logic [N_ADC-1:0]	osf_activate,
	output	logic [15:0]		osf_cycle_delay,
	output	logic [5:0]		osf_osm,
	output	logic [N_ADC-1:0]	osf_update_en,

	// pid core
	output	logic [N_ADC-1:0]	pid_lock_en,
	output	logic [N_ADC-1:0]	pid_clear,
	output	logic [15:0]		pid_setpoint,
	output	logic [15:0]		pid_p_coef,
	output	logic [15:0]		pid_i_coef,
	output	logic [15:0]		pid_d_coef,
	output	logic [N_ADC-1:0]	pid_update_en,

	// router
	output	logic [3:0]		rtr_src_sel,
	output	logic [3:0]		rtr_dest_sel,
	output	logic [N_OUT-1:0]	rtr_output_active,

	// output preprocessor
	output	logic [47:0]		opp_min,
	output	logic [47:0]		opp_max,
	output	logic [47:0]		opp_init,
	output	logic [N_OUT-1:0]	opp_update_en,

	// dac and global
	output	logic			dac_ref_set,
	output	logic			module_update,
	output	logic			sys_reset
);

	import ep_pkg::*;
	import cfg_pkg::*;

	osf_cfg_t	osf_cfg;
	pid_cfg_t	pid_cfg;
	rtr_cfg_t	rtr_cfg;
	opp_cfg_t	opp_cfg;
	trig_t		trig;
	logic [15:0]	adc_os_word;
	host_reply_t	cfg_reply;
	host_reply_t	adc_reply;

	////////////////////
	// blocks
	////////////////////

	config_regs config_regs_i (
		.clk50_in	(clk50_in),
		.arst_n		(arst_n),
		.host_cmd	(host_cmd),
		.osf_cfg	(osf_cfg),
		.pid_cfg	(pid_cfg),
		.rtr_cfg	(rtr_cfg),
		.opp_cfg	(opp_cfg),
		.adc_os_word	(adc_os_word),
		.trig		(trig),
		.cfg_reply	(cfg_reply)
	);

	adc_readback #(
		.N_ADC		(N_ADC),
		.W_ADC_DATA	(W_ADC_DATA),
		.FIFO_DEPTH	(FIFO_DEPTH)
	) adc_readback_i (
		.clk50_in	(clk50_in),
		.arst_n		(arst_n),
		.host_cmd	(host_cmd),
		.adc_data_valid	(adc_data_valid),
		.adc_data_a	(adc_data_a),
		.adc_data_b	(adc_data_b),
		.adc_reply	(adc_reply)
	);

	reply_merge reply_merge_i (
		.clk50_in	(clk50_in),
		.arst_n		(arst_n),
		.host_cmd	(host_cmd),
		.cfg_reply	(cfg_reply),
		.adc_reply	(adc_reply),
		.host_reply	(host_reply)
	);

	////////////////////
	// port slicing, low bits
	////////////////////

	assign adc_os     = adc_os_word[2:0];
	assign adc_cstart = trig.adc_cstart[0];

	assign osf_activate    = osf_cfg.activate[N_ADC-1:0];
	assign osf_cycle_delay = osf_cfg.cycle_delay;
	assign osf_osm         = osf_cfg.osm[5:0];
	assign osf_update_en   = osf_cfg.update_en[N_ADC-1:0];

	assign pid_lock_en   = pid_cfg.lock_en[N_ADC-1:0];
	assign pid_clear     = trig.pid_clear[N_ADC-1:0];	// per channel clear
	assign pid_setpoint  = pid_cfg.setpoint;
	assign pid_p_coef    = pid_cfg.p_coef;
	assign pid_i_coef    = pid_cfg.i_coef;
	assign pid_d_coef    = pid_cfg.d_coef;
	assign pid_update_en = pid_cfg.update_en[N_ADC-1:0];

	assign rtr_src_sel       = rtr_cfg.src_sel[3:0];
	assign rtr_dest_sel      = rtr_cfg.dest_sel[3:0];
	assign rtr_output_active = rtr_cfg.output_active[N_OUT-1:0];

	assign opp_min       = opp_cfg.min;
	assign opp_max       = opp_cfg.max;
	assign opp_init      = opp_cfg.init;
	assign opp_update_en = opp_cfg.update_en[N_OUT-1:0];

	assign dac_ref_set   = trig.dac_ref_set[0];
	assign module_update = trig.module_update[0];
	assign sys_reset     = trig.sys_reset[0];

endmodule

// File: verif/fp_properties.sv
`timescale 1ns/10ps

module fp_properties #(
	parameter int N_ADC = 8
) (
	input	logic			clk50_in,
	input	logic			arst_n,
	input	ep_pkg::host_cmd_t	host_cmd,
	input	ep_pkg::host_reply_t	host_reply,
	input	logic			adc_cstart,
	input	logic [N_ADC-1:0]	pid_clear,
	input	logic			dac_ref_set,
	input	logic			module_update,
	input	logic			sys_reset
);

	import ep_pkg::*;

	logic	rd;
	logic	wr;
	logic	trig_wr;
	logic	pulse;
	int	fails = 0;	// read by the testbench at the end

	assign rd      = host_cmd.strobe & ~host_cmd.write;
	assign wr      = host_cmd.strobe & host_cmd.write;
	assign trig_wr = wr && host_cmd.addr >= ADC_CSTART_TEP && host_cmd.addr <= SYS_RESET_TEP;
	assign pulse   = adc_cstart | (|pid_clear) | dac_ref_set | module_update | sys_reset;

	reply_after_read: assert property (@(posedge clk50_in) disable iff (!arst_n)
		rd |-> ##2 host_reply.valid)
		else begin $error("no reply two cycles after a read"); fails++; end

	no_reply_after_write: assert property (@(posedge clk50_in) disable iff (!arst_n)
		wr |-> ##2 !host_reply.valid)
		else begin $error("reply after a write"); fails++; end

	reply_needs_read: assert property (@(posedge clk50_in) disable iff (!arst_n)
		host_reply.valid |-> $past(rd, 2))
		else begin $error("reply without a read"); fails++; end

	// a pulse only in the cycle after its write
	pulse_after_write: assert property (@(posedge clk50_in) disable iff (!arst_n)
		pulse |-> $past(trig_wr))
		else begin $error("trigger pulse without a trigger write"); fails++; end

endmodule

// File: verif/fp_checker.sv
`timescale 1ns/10ps

module fp_checker #(
	parameter int N_ADC      = 8,
	parameter int W_ADC_DATA = 18,
	parameter int N_OUT      = 8,
	parameter int FIFO_DEPTH = 16
) (
	input	logic			clk50_in,
	input	logic			arst_n,
	input	ep_pkg::host_cmd_t	host_cmd,
	input	ep_pkg::host_reply_t	host_reply,
	input	logic [N_ADC-1:0]	adc_data_valid,
	input	logic [W_ADC_DATA-1:0]	adc_data_a,
	input	logic [W_ADC_DATA-1:0]	adc_data_b,
	input	logic [2:0]		adc_os,
	input	logic			adc_cstart,
	input	logic [N_ADC-1:0]	osf_activate,
	input	logic [15:0]		osf_cycle_delay,
	input	logic [5:0]		osf_osm,
	input	logic [N_ADC-1:0]	osf_update_en,
	input	logic [N_ADC-1:0]	pid_lock_en,
	input	logic [N_ADC-1:0]	pid_clear,
	input	logic [15:0]		pid_setpoint,
	input	logic [15:0]		pid_p_coef,
	input	logic [15:0]		pid_i_coef,
	input	logic [15:0]		pid_d_coef,
	input	logic [N_ADC-1:0]	pid_update_en,
	input	logic [3:0]		rtr_src_sel,
	input	logic [3:0]		rtr_dest_sel,
	input	logic [N_OUT-1:0]	rtr_output_active,
	input	logic [47:0]		opp_min,
	input	logic [47:0]		opp_max,
	input	logic [47:0]		opp_init,
	input	logic [N_OUT-1:0]	opp_update_en,
	input	logic			dac_ref_set,
	input	logic			module_update,
	input	logic			sys_reset,
	input	logic			lit_en,
	input	logic [15:0]		lit_data,
	input	logic			test_end,
	input	int			test_num,
	output	logic			busy,
	output	int			err_total,
	output	int			tests_run,
	output	int			tests_failed
);

	import ep_pkg::*;

	typedef struct packed {
		host_reply_t	reply;
		logic		lit_en;	// also compare with the file value
		logic [15:0]	lit;
	} exp_t;

	exp_t			stage [2];	// reply pipeline, stage 1 is due now
	logic [15:0]		wi [N_WIRE_IN];
	logic [15:0]		trig_now [5];
	logic [W_ADC_DATA-1:0]	slot [N_ADC];
	logic [15:0]		fifo_q [$];
	int			err_test;

	assign busy = stage[0].reply.valid | stage[1].reply.valid;

	task automatic check(input string what, input logic [47:0] got, input logic [47:0] exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			err_total++;
			err_test++;
		end
	endtask

	////////////////////
	// output compare
	////////////////////

	task automatic check_outputs();
		check("adc_os", adc_os, wi[ADC_OS_WEP][2:0]);
		check("osf_activate", osf_activate, wi[OSF_ACTIVATE_WEP][N_ADC-1:0]);
		check("osf_cycle_delay", osf_cycle_delay, wi[OSF_CYCLE_DELAY_WEP]);
		check("osf_osm", osf_osm, wi[OSF_OSM_WEP][5:0]);
		check("osf_update_en", osf_update_en, wi[OSF_UPDATE_EN_WEP][N_ADC-1:0]);
		check("pid_lock_en", pid_lock_en, wi[PID_LOCK_EN_WEP][N_ADC-1:0]);
		check("pid_setpoint", pid_setpoint, wi[PID_SETPOINT_WEP]);
		check("pid_p_coef", pid_p_coef, wi[PID_P_COEF_WEP]);
		check("pid_i_coef", pid_i_coef, wi[PID_I_COEF_WEP]);
		check("pid_d_coef", pid_d_coef, wi[PID_D_COEF_WEP]);
		check("pid_update_en", pid_update_en, wi[PID_UPDATE_EN_WEP][N_ADC-1:0]);
		check("rtr_src_sel", rtr_src_sel, wi[RTR_SRC_SEL_WEP][3:0]);
		check("rtr_dest_sel", rtr_dest_sel, wi[RTR_DEST_SEL_WEP][3:0]);
		check("rtr_output_active", rtr_output_active, wi[RTR_OUTPUT_ACTIVE_WEP][N_OUT-1:0]);
		check("opp_min", opp_min, {wi[OPP_MIN2_WEP], wi[OPP_MIN1_WEP], wi[OPP_MIN0_WEP]});
		check("opp_max", opp_max, {wi[OPP_MAX2_WEP], wi[OPP_MAX1_WEP], wi[OPP_MAX0_WEP]});
		check("opp_init", opp_init, {wi[OPP_INIT2_WEP], wi[OPP_INIT1_WEP], wi[OPP_INIT0_WEP]});
		check("opp_update_en", opp_update_en, wi[OPP_UPDATE_EN_WEP][N_OUT-1:0]);
		// trigger order follows the endpoint addresses
		check("adc_cstart", adc_cstart, trig_now[0][0]);
		check("pid_clear", pid_clear, trig_now[1][N_ADC-1:0]);
		check("dac_ref_set", dac_ref_set, trig_now[2][0]);
		check("module_update", module_update, trig_now[3][0]);
		check("sys_reset", sys_reset, trig_now[4][0]);
	endtask

	task automatic check_reply(input exp_t e);
		check("reply valid", host_reply.valid, e.reply.valid);
		if (e.reply.valid) begin
			check("reply unmapped", host_reply.unmapped, e.reply.unmapped);
			check("reply pipe_empty", host_reply.pipe_empty, e.reply.pipe_empty);
			check("reply data", host_reply.data, e.reply.data);
			if (e.lit_en)
				check("reply data against file", host_reply.data, e.lit);
		end
	endtask

	////////////////////
	// model
	////////////////////

	task automatic step_model();
		exp_t		e;
		logic [7:0]	addr;

		e    = '0;
		addr = host_cmd.addr;
		for (int i = 0; i < 5; i++)
			trig_now[i] = 16'h0;	// pulses last one cycle
		if (host_cmd.strobe && !host_cmd.write) begin
			e.reply.valid = 1'b1;
			e.lit_en      = lit_en;
			e.lit         = lit_data;
			if (addr < N_WIRE_IN) begin
				e.reply.data = wi[addr];
			end else if (addr >= ADC_DATA0_OWEP && addr < ADC_DATA0_OWEP + N_ADC) begin
				e.reply.data = slot[addr - ADC_DATA0_OWEP][W_ADC_DATA-1 -: 16];
			end else if (addr == OSF_PIPE_PEP) begin
				if (fifo_q.size() == 0)
					e.reply.pipe_empty = 1'b1;	// data stays 0
				else
					e.reply.data = fifo_q.pop_front();
			end else begin
				e.reply.unmapped = 1'b1;
				e.reply.data     = UNMAPPED_WORD;
			end
		end
		if (host_cmd.strobe && host_cmd.write) begin
			if (addr < N_WIRE_IN)
				wi[addr] = host_cmd.data;
			else if (addr >= ADC_CSTART_TEP && addr <= SYS_RESET_TEP)
				trig_now[addr - ADC_CSTART_TEP] = host_cmd.data;
		end
		// low half from a, high half from b, a first
		for (int i = 0; i < N_ADC/2; i++) begin
			if (adc_data_valid[i])
				slot[i] = adc_data_a;
			else if (adc_data_valid[i + N_ADC/2])
				slot[i + N_ADC/2] = adc_data_b;
		end
		if (adc_data_valid[0] && fifo_q.size() < FIFO_DEPTH)
			fifo_q.push_back(adc_data_a[W_ADC_DATA-1 -: 16]);
		stage[1] = stage[0];
		stage[0] = e;
	endtask

	always @(posedge clk50_in or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 2; i++)
				stage[i] = '0;
			for (int i = 0; i < N_WIRE_IN; i++)
				wi[i] = 16'h0;
			for (int i = 0; i < 5; i++)
				trig_now[i] = 16'h0;
			for (int i = 0; i < N_ADC; i++)
				slot[i] = '0;
			fifo_q.delete();
			err_total    = 0;
			err_test     = 0;
			tests_run    = 0;
			tests_failed = 0;
		end else begin
			check_reply(stage[1]);	// outputs still hold pre-edge values
			check_outputs();
			step_model();
			if (test_end) begin
				tests_run++;
				if (err_test == 0) begin
					$display("test %0d passed", test_num);
				end else begin
					tests_failed++;
					$display("test %0d failed with %0d errors", test_num, err_test);
				end
				err_test = 0;
			end
		end
	end

endmodule

// File: verif/frontpanel_interface_tb.sv
`timescale 1ns/10ps

module frontpanel_interface_tb;

	import ep_pkg::*;

	localparam int N_ADC      = 8;
	localparam int W_ADC_DATA = 18;
	localparam int N_OUT      = 8;
	localparam int FIFO_DEPTH = 16;

	logic			clk50_in;
	logic			arst_n;
	host_cmd_t		host_cmd;
	host_reply_t		host_reply;
	logic [N_ADC-1:0]	adc_data_valid;
	logic [W_ADC_DATA-1:0]	adc_data_a;
	logic [W_ADC_DATA-1:0]	adc_data_b;
	logic [2:0]		adc_os;
	logic			adc_cstart;
	logic [N_ADC-1:0]	osf_activate;
	logic [15:0]		osf_cycle_delay;
	logic [5:0]		osf_osm;
	logic [N_ADC-1:0]	osf_update_en;
	logic [N_ADC-1:0]	pid_lock_en;
	logic [N_ADC-1:0]	pid_clear;
	logic [15:0]		pid_setpoint;
	logic [15:0]		pid_p_coef;
	logic [15:0]		pid_i_coef;
	logic [15:0]		pid_d_coef;
	logic [N_ADC-1:0]	pid_update_en;
	logic [3:0]		rtr_src_sel;
	logic [3:0]		rtr_dest_sel;
	logic [N_OUT-1:0]	rtr_output_active;
	logic [47:0]		opp_min;
	logic [47:0]		opp_max;
	logic [47:0]		opp_init;
	logic [N_OUT-1:0]	opp_update_en;
	logic			dac_ref_set;
	logic			module_update;
	logic			sys_reset;

	// checker side
	logic		lit_en;	// literal expected data rides with a read
	logic [15:0]	lit_data;
	logic		test_end;
	int		test_num;
	logic		busy;
	int		err_total;
	int		tests_run;
	int		tests_failed;

	int		cycles;
	int		cycle_limit;
	int		bad_lines;
	logic [31:0]	rng;

	frontpanel_interface #(
		.N_ADC		(N_ADC),
		.W_ADC_DATA	(W_ADC_DATA),
		.N_OUT		(N_OUT),
		.FIFO_DEPTH	(FIFO_DEPTH)
	) dut_i (.*);

	fp_checker #(
		.N_ADC		(N_ADC),
		.W_ADC_DATA	(W_ADC_DATA),
		.N_OUT		(N_OUT),
		.FIFO_DEPTH	(FIFO_DEPTH)
	) chk_i (.*);

	bind frontpanel_interface fp_properties #(.N_ADC(N_ADC)) props_i (.*);

	initial clk50_in = 1'b0;
	always #20 clk50_in = ~clk50_in;	// 40 ns period

	////////////////////
	// drivers
	////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic send(input logic wr, input logic [7:0] addr, input logic [15:0] data,
		input logic lit, input logic [15:0] exp_data);
		@(negedge clk50_in);
		host_cmd       = '{strobe: 1'b1, write: wr, addr: addr, data: data};
		lit_en         = lit;
		lit_data       = exp_data;
		adc_data_valid = '0;
	endtask

	task automatic sample(input logic [N_ADC-1:0] v, input logic [W_ADC_DATA-1:0] a,
		input logic [W_ADC_DATA-1:0] b);
		@(negedge clk50_in);
		host_cmd       = '0;
		lit_en         = 1'b0;
		adc_data_valid = v;
		adc_data_a     = a;
		adc_data_b     = b;
	endtask

	task automatic idle();
		@(negedge clk50_in);
		host_cmd       = '0;
		lit_en         = 1'b0;
		adc_data_valid = '0;
	endtask

	// random word into every wire-in, each read straight back
	task automatic write_readback_all();
		for (int a = 0; a < N_WIRE_IN; a++) begin
			rng = xorshift32(rng);
			send(1'b1, a, rng[15:0], 1'b0, 16'h0);
			send(1'b0, a, 16'h0, 1'b0, 16'h0);
		end
	endtask

	task automatic finish_test();
		idle();
		while (busy)	// last replies still in flight
			@(negedge clk50_in);
		test_end = 1'b1;
		@(negedge clk50_in);
		test_end = 1'b0;
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		int		fd;
		int		n;
		logic		open;
		string		line;
		byte		op;
		logic [31:0]	f1;
		logic [31:0]	f2;
		logic [31:0]	f3;

		host_cmd       = '0;
		adc_data_valid = '0;
		adc_data_a     = '0;
		adc_data_b     = '0;
		lit_en         = 1'b0;
		lit_data       = '0;
		test_end       = 1'b0;
		test_num       = 0;
		arst_n         = 1'b0;
		cycles         = 0;
		cycle_limit    = 100;
		bad_lines      = 0;
		open           = 1'b0;
		rng            = 32'hdeb61445;

		fd = $fopen("verif/fp_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open verif/fp_stimulus.txt");
			$display("Testbench failed");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0)
					cycle_limit += 4;
			end
			$fclose(fd);
			fd = $fopen("verif/fp_stimulus.txt", "r");

			repeat (3) @(negedge clk50_in);
			arst_n = 1'b1;

			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n <= 1 || line[0] == "#")
					continue;
				n = $sscanf(line, "%c %h %h %h", op, f1, f2, f3);
				case (op)
					"T": begin
						if (open)
							finish_test();
						test_num = f1;
						open     = 1'b1;
					end
					"A": write_readback_all();
					"W": send(1'b1, f1, f2, 1'b0, 16'h0);
					"R": send(1'b0, f1, 16'h0, 1'b0, 16'h0);
					"C": send(1'b0, f1, 16'h0, 1'b1, f2);
					"S": sample(f1, f2, f3);
					"N": for (int i = 0; i < f1; i++)
						sample(1, f2 + 4 * i, 0);	// upper word steps by one
					"B": for (int i = 0; i < f1; i++)
						send(1'b0, f2, 16'h0, 1'b0, 16'h0);
					default: begin
						$display("stimulus line not understood: %s", line);
						bad_lines++;
					end
				endcase
			end
			$fclose(fd);
			if (open)
				finish_test();

			$display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
				tests_run, tests_failed, err_total, dut_i.props_i.fails);
			if (err_total == 0 && tests_failed == 0 && bad_lines == 0 &&
				dut_i.props_i.fails == 0) begin
				$display("Testbench passed");
			end else begin
				$display("Testbench failed");
			end
			$finish;
		end
	end

	// run limit from the stimulus length
	always @(posedge clk50_in) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout, run did not end within %0d cycles", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
	end

endmodule

// File: verif/fp_stimulus.txt
# op a b c (hex): T test number, A random write and readback of every wire-in,
# W write addr data, R read addr, C read addr expect, S sample valid a b,
# N count samples on channel 0 from a upward, B count reads of addr
T 1
A
T 2
W 41 00a5
W 44 0001
W 40 0003
W 42 0001
W 43 0000
T 3
S 02 12340 2aaa8
S 22 3fffc 15554
S 40 00000 2aaa8
C 21 ffff
C 25 0000
C 26 aaaa
R 22
T 4
C a0 0000
N 12 00000
B 11 a0
T 5
W 05 1234
R 05
C 26 aaaa
C 77 dead
C 40 dead
C a0 0000
R 05

// File: compile.f
common/ep_pkg.sv
common/cfg_pkg.sv
logic/config_regs.sv
logic/adc_readback.sv
logic/reply_merge.sv
frontpanel_interface/frontpanel_interface.sv
verif/fp_properties.sv
verif/fp_checker.sv
verif/frontpanel_interface_tb.sv

// File: Bender.yml
package:
  name: frontpanel_interface

sources:
  - common/ep_pkg.sv
  - common/cfg_pkg.sv
  - logic/config_regs.sv
  - logic/adc_readback.sv
  - logic/reply_merge.sv
  - frontpanel_interface/frontpanel_interface.sv
  - target: simulation
    files:
      - verif/fp_properties.sv
      - verif/fp_checker.sv
      - verif/frontpanel_interface_tb.sv
